// File: Makefile
TOP = ob_table_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -j 0 -f src.f --top-module $(TOP) -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Finished with no errors"

clean:
	rm -rf obj_dir

// File: hw/ob_edge_if.sv
interface ob_edge_if import ob_pkg::*; ();

  // Head slot is written on the coming edge
  logic   head_en;
  entry_t head_next;

  // Reject slot is written on the coming edge
  logic   reject_en;
  entry_t reject_next;

  modport array (
    output head_en,
    output head_next,
    output reject_en,
    output reject_next
  );

  modport out (
    input head_en,
    input head_next,
    input reject_en,
    input reject_next
  );

endinterface

// File: hw/ob_entry_array.sv
module ob_entry_array import ob_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  reject_pop,
  ob_table_ops_if.array         ops,
  output entry_t [SLOT_CNT-1:0] slots,
  output slot_mask_t            slot_vld,
  ob_edge_if.array              edge_o
);

  entry_t [SLOT_CNT-1:0] slot_q;
  entry_t [SLOT_CNT-1:0] slot_next;
  slot_mask_t            slot_en;

  always_comb begin
    // Default is hold
    slot_next = slot_q;

    // Head slot, nothing above it to shift down from
    slot_en[TABLE_DEPTH] = ops.install[TABLE_DEPTH] | ops.shift_up[TABLE_DEPTH];
    if (ops.install[TABLE_DEPTH]) begin
      slot_next[TABLE_DEPTH] = ops.insert_entry;
    end else if (ops.shift_up[TABLE_DEPTH]) begin
      slot_next[TABLE_DEPTH] = slot_q[TABLE_DEPTH-1];
    end

    // Middle slots
    for (int i = TABLE_DEPTH - 1; i > 0; i--) begin
      slot_en[i] = ops.install[i] | ops.shift_up[i] | ops.shift_dn[i];
      if (ops.install[i]) begin
        slot_next[i] = ops.insert_entry;
      end else if (ops.shift_up[i]) begin
        slot_next[i] = slot_q[i-1];
      end else if (ops.shift_dn[i]) begin
        slot_next[i] = slot_q[i+1];
      end
    end

    // Reject slot, also cleared by the consumer
    slot_en[0] = ops.install[0] | ops.shift_up[0] | ops.shift_dn[0] | reject_pop;
    if (ops.install[0]) begin
      slot_next[0] = ops.insert_entry;
    end else if (ops.shift_up[0]) begin
      // Nothing below the reject slot to pull up
      slot_next[0] = EMPTY_ENTRY;
    end else if (ops.shift_dn[0]) begin
      // Worst live entry falls out of the book
      slot_next[0] = slot_q[1];
    end else if (reject_pop) begin
      slot_next[0] = EMPTY_ENTRY;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < SLOT_CNT; i++) begin
        slot_q[i] <= EMPTY_ENTRY;
      end
    end else begin
      for (int i = 0; i < SLOT_CNT; i++) begin
        if (slot_en[i]) begin
          slot_q[i] <= slot_next[i];
        end
      end
    end
  end

  // A slot is live when it carries a real price
  always_comb begin
    for (int i = 0; i < SLOT_CNT; i++) begin
      slot_vld[i] = (slot_q[i].price != INVALID_PRICE);
    end
  end

  assign slots = slot_q;

  // Head and reject next-state for the output registers
  assign edge_o.head_en     = slot_en[TABLE_DEPTH];
  assign edge_o.head_next   = slot_next[TABLE_DEPTH];
  assign edge_o.reject_en   = slot_en[0];
  assign edge_o.reject_next = slot_next[0];

endmodule

// File: hw/ob_head_reject_out.sv
module ob_head_reject_out import ob_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  ob_edge_if.out    edge_i,
  output logic      head_vld_r,
  output logic      head_did_update_r,
  output entry_t    head_r,
  output logic      reject_vld_r,
  output entry_t    reject_r
);

  logic head_next_vld;
  logic reject_next_vld;

  assign head_next_vld   = (edge_i.head_next.price != INVALID_PRICE);
  assign reject_next_vld = (edge_i.reject_next.price != INVALID_PRICE);

  // Valid bits and the head change pulse
  always_ff @(posedge clk) begin
    if (rst) begin
      head_vld_r        <= 1'b0;
      head_did_update_r <= 1'b0;
      reject_vld_r      <= 1'b0;
    end else begin
      // Pulses on any head write, including the head going empty
      head_did_update_r <= edge_i.head_en;
      if (edge_i.head_en) begin
        head_vld_r <= head_next_vld;
      end
      // A new reject overwrites an unconsumed one
      if (edge_i.reject_en) begin
        reject_vld_r <= reject_next_vld;
      end
    end
  end

  // Entries only load with real content
  always_ff @(posedge clk) begin
    if (edge_i.head_en && head_next_vld) begin
      head_r <= edge_i.head_next;
    end
    if (edge_i.reject_en && reject_next_vld) begin
      reject_r <= edge_i.reject_next;
    end
  end

endmodule

// File: hw/ob_pkg.sv
package ob_pkg;

  // Live slots in the ask table
  localparam int TABLE_DEPTH = 8;

  // Live slots plus the reject slot at index 0
  // Slot TABLE_DEPTH is the head
  localparam int SLOT_CNT = TABLE_DEPTH + 1;

  // Plain binary price, lower is better on the ask side
  typedef logic [15:0] price_t;

  // Resting order quantity
  typedef logic [15:0] quantity_t;

  // Order identifier, unique among resting orders
  typedef logic [7:0] uid_t;

  // One table entry, 40 bits
  typedef struct packed {
    uid_t      uid;
    quantity_t quantity;
    price_t    price;
  } entry_t;

  // One bit per slot, bit 0 is the reject slot
  typedef logic [SLOT_CNT-1:0] slot_mask_t;

  // Maximum price marks an empty slot
  localparam price_t INVALID_PRICE = '1;

  // Value of every slot out of reset
  localparam entry_t EMPTY_ENTRY = '{
    uid:      '0,
    quantity: '0,
    price:    INVALID_PRICE
  };

endpackage

// File: hw/ob_slot_ctrl.sv
module ob_slot_ctrl import ob_pkg::*; (
  input  logic                  insert,
  input  entry_t                insert_entry_in,
  input  logic                  cancel,
  input  uid_t                  cancel_uid,
  input  logic                  head_pop,
  input  entry_t [SLOT_CNT-1:0] slots,
  input  slot_mask_t            slot_vld,
  output logic                  cancel_hit,
  output entry_t                cancel_entry,
  ob_table_ops_if.ctrl          ops
);

  slot_mask_t insert_match;
  slot_mask_t install_sel;
  slot_mask_t shift_dn_mask;
  slot_mask_t cancel_match;
  slot_mask_t cancel_mask;

  // Insert placement
  always_comb begin
    // Slots strictly worse than the new price
    // Equal prices do not match so ties queue behind the resting order
    insert_match = '0;
    for (int i = 1; i < SLOT_CNT; i++) begin
      insert_match[i] = insert & (insert_entry_in.price < slots[i].price);
    end
    // Reject slot always catches an order worse than the whole book
    insert_match[0] = insert;

    // Highest matching index is closest to the head, so it wins
    install_sel = '0;
    for (int i = 0; i < SLOT_CNT; i++) begin
      if (insert_match[i]) begin
        install_sel    = '0;
        install_sel[i] = 1'b1;
      end
    end
  end

  // Everything below the install slot moves one step toward reject
  always_comb begin
    logic seen;
    seen = 1'b0;
    for (int i = SLOT_CNT - 1; i >= 0; i--) begin
      shift_dn_mask[i] = seen;
      seen             = seen | install_sel[i];
    end
  end

  // Cancel lookup by uid
  always_comb begin
    logic seen;
    // At most one valid slot can carry the uid
    for (int i = 0; i < SLOT_CNT; i++) begin
      cancel_match[i] = cancel & slot_vld[i] & (slots[i].uid == cancel_uid);
    end
    cancel_hit = |cancel_match;

    // Hit entry out, zero on a miss
    cancel_entry = '0;
    for (int i = 0; i < SLOT_CNT; i++) begin
      if (cancel_match[i]) begin
        cancel_entry = slots[i];
      end
    end

    // Hit slot and all below pull up to close the gap
    seen = 1'b0;
    for (int i = SLOT_CNT - 1; i >= 0; i--) begin
      seen           = seen | cancel_match[i];
      cancel_mask[i] = seen;
    end
  end

  assign ops.install      = install_sel;
  assign ops.shift_dn     = shift_dn_mask;
  // Head pop moves the whole table up
  assign ops.shift_up     = head_pop ? '1 : cancel_mask;
  assign ops.insert_entry = insert_entry_in;

endmodule

// File: hw/ob_table.sv
module ob_table import ob_pkg::*; (
  input  logic   clk,
  input  logic   rst,
  // New order
  input  logic   insert,
  input  entry_t insert_entry,
  // Cancel by uid, result same cycle
  input  logic   cancel,
  input  uid_t   cancel_uid,
  output logic   cancel_hit,
  output entry_t cancel_entry,
  // Head of book
  input  logic   head_pop,
  output logic   head_vld_r,
  output logic   head_did_update_r,
  output entry_t head_r,
  // Rejected order
  input  logic   reject_pop,
  output logic   reject_vld_r,
  output entry_t reject_r
);

  entry_t [SLOT_CNT-1:0] slots;
  slot_mask_t            slot_vld;

  ob_table_ops_if u_ops_if ();
  ob_edge_if      u_edge_if ();

  // Compare and mask generation
  ob_slot_ctrl u_slot_ctrl (
    .insert          (insert),
    .insert_entry_in (insert_entry),
    .cancel          (cancel),
    .cancel_uid      (cancel_uid),
    .head_pop        (head_pop),
    .slots           (slots),
    .slot_vld        (slot_vld),
    .cancel_hit      (cancel_hit),
    .cancel_entry    (cancel_entry),
    .ops             (u_ops_if.ctrl)
  );

  // Sorted slot storage
  ob_entry_array u_entry_array (
    .clk        (clk),
    .rst        (rst),
    .reject_pop (reject_pop),
    .ops        (u_ops_if.array),
    .slots      (slots),
    .slot_vld   (slot_vld),
    .edge_o     (u_edge_if.array)
  );

  // Registered head and reject
  ob_head_reject_out u_head_reject_out (
    .clk               (clk),
    .rst               (rst),
    .edge_i            (u_edge_if.out),
    .head_vld_r        (head_vld_r),
    .head_did_update_r (head_did_update_r),
    .head_r            (head_r),
    .reject_vld_r      (reject_vld_r),
    .reject_r          (reject_r)
  );

endmodule

// File: hw/ob_table_ops_if.sv
interface ob_table_ops_if import ob_pkg::*; ();

  // One-hot, slot that takes the new order
  slot_mask_t install;

  // Unary, slots that pull from the slot below (pop or cancel)
  slot_mask_t shift_up;

  // Unary, slots that pull from the slot above (insert)
  slot_mask_t shift_dn;

  // Order being inserted this cycle
  entry_t insert_entry;

  modport ctrl (
    output install,
    output shift_up,
    output shift_dn,
    output insert_entry
  );

  modport array (
    input install,
    input shift_up,
    input shift_dn,
    input insert_entry
  );

endinterface

// File: src.f
+incdir+tests
hw/ob_pkg.sv
hw/ob_table_ops_if.sv
hw/ob_edge_if.sv
hw/ob_slot_ctrl.sv
hw/ob_entry_array.sv
hw/ob_head_reject_out.sv
hw/ob_table.sv
tests/ob_table_tb.sv

// File: tests/ob_table_checks.svh
`ifndef OB_TABLE_CHECKS_SVH
`define OB_TABLE_CHECKS_SVH

// Running totals over the whole run
int check_count = 0;
int error_count = 0;

// Whole entry, uid and quantity and price together
task automatic check_entry(input string what, input entry_t exp, input entry_t act);
  check_count++;
  if (act !== exp) begin
    error_count++;
    $display("MISMATCH %s %s: expected %h actual %h", cur_test, what, exp, act);
  end
endtask

// Single status bit, strobe or valid
task automatic check_bit(input string what, input logic exp, input logic act);
  check_count++;
  if (act !== exp) begin
    error_count++;
    $display("MISMATCH %s %s: expected %b actual %b", cur_test, what, exp, act);
  end
endtask

// Order identity only, used for sequence checks
task automatic check_uid(input string what, input uid_t exp, input uid_t act);
  check_count++;
  if (act !== exp) begin
    error_count++;
    $display("MISMATCH %s %s: expected %h actual %h", cur_test, what, exp, act);
  end
endtask

`endif

// File: tests/ob_table_tb.sv
module ob_table_tb import ob_pkg::*; ();

  // Directed tests take under 200 cycles, ten times that is the hard stop
  localparam int MAX_CYCLES = 2000;

  logic   clk;
  logic   rst;
  logic   insert;
  entry_t insert_entry;
  logic   cancel;
  uid_t   cancel_uid;
  logic   cancel_hit;
  entry_t cancel_entry;
  logic   head_pop;
  logic   head_vld_r;
  logic   head_did_update_r;
  entry_t head_r;
  logic   reject_pop;
  logic   reject_vld_r;
  entry_t reject_r;

  // Reference book, index 0 is the best (lowest) price
  entry_t model_q[$];
  // Last order pushed out of the reference book
  entry_t model_reject;

  integer seed      = 16378;
  uid_t   next_uid  = 8'd1;
  int     cycle_cnt = 0;
  string  cur_test  = "";

  `include "ob_table_checks.svh"

  ob_table dut (
    .clk               (clk),
    .rst               (rst),
    .insert            (insert),
    .insert_entry      (insert_entry),
    .cancel            (cancel),
    .cancel_uid        (cancel_uid),
    .cancel_hit        (cancel_hit),
    .cancel_entry      (cancel_entry),
    .head_pop          (head_pop),
    .head_vld_r        (head_vld_r),
    .head_did_update_r (head_did_update_r),
    .head_r            (head_r),
    .reject_pop        (reject_pop),
    .reject_vld_r      (reject_vld_r),
    .reject_r          (reject_r)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  // Hard stop if a test stalls
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("Finished with errors");
      $finish;
    end
  end

  // Sorted insert, equal prices queue behind, returns the position taken
  function automatic int model_insert(input entry_t e);
    int pos;
    pos = model_q.size();
    for (int i = model_q.size() - 1; i >= 0; i--) begin
      if (model_q[i].price > e.price) begin
        pos = i;
      end
    end
    model_q.insert(pos, e);
    // Worst order falls out once the book is over full
    if (model_q.size() > TABLE_DEPTH) begin
      model_reject = model_q.pop_back();
    end
    return pos;
  endfunction

  function automatic void model_cancel(input uid_t uid);
    int idx;
    idx = -1;
    for (int i = 0; i < model_q.size(); i++) begin
      if (model_q[i].uid == uid) begin
        idx = i;
      end
    end
    if (idx >= 0) begin
      model_q.delete(idx);
    end
  endfunction

  // Fresh uid and a random quantity
  task automatic new_entry(input price_t price, output entry_t e);
    logic [31:0] rnd;
    rnd        = $random(seed);
    e.uid      = next_uid;
    e.quantity = rnd[15:0];
    e.price    = price;
    next_uid++;
  endtask

  // Single cycle strobes, set and cleared on falling edges
  task automatic drive_insert(input entry_t e);
    @(negedge clk);
    insert       = 1'b1;
    insert_entry = e;
    @(negedge clk);
    insert = 1'b0;
  endtask

  task automatic drive_pop();
    @(negedge clk);
    head_pop = 1'b1;
    @(negedge clk);
    head_pop = 1'b0;
  endtask

  task automatic drive_reject_pop();
    @(negedge clk);
    reject_pop = 1'b1;
    @(negedge clk);
    reject_pop = 1'b0;
  endtask

  task automatic drive_cancel(input uid_t uid, output logic hit, output entry_t ent);
    @(negedge clk);
    cancel     = 1'b1;
    cancel_uid = uid;
    // Hit is combinational, sample once it has settled
    #2;
    hit = cancel_hit;
    ent = cancel_entry;
    @(negedge clk);
    cancel = 1'b0;
  endtask

  // Head only pulses when the new order lands at the front
  task automatic insert_and_check(input entry_t e);
    int pos;
    pos = model_insert(e);
    drive_insert(e);
    check_entry("head after insert", model_q[0], head_r);
    check_bit("head_vld after insert", 1'b1, head_vld_r);
    check_bit("head pulse after insert", pos == 0, head_did_update_r);
  endtask

  task automatic pop_and_check();
    entry_t exp;
    exp = model_q.pop_front();
    check_uid("pop order", exp.uid, head_r.uid);
    drive_pop();
    check_bit("head pulse after pop", 1'b1, head_did_update_r);
    if (model_q.size() > 0) begin
      check_entry("head after pop", model_q[0], head_r);
    end else begin
      check_bit("head_vld after last pop", 1'b0, head_vld_r);
    end
  endtask

  task automatic report_test(input int errs_at_start);
    if (error_count == errs_at_start) begin
      $display("test %s: pass", cur_test);
    end else begin
      $display("test %s: FAIL, %0d errors", cur_test, error_count - errs_at_start);
    end
  endtask

  task automatic test_reset();
    int errs;
    cur_test = "reset";
    errs     = error_count;
    check_bit("head_vld_r", 1'b0, head_vld_r);
    check_bit("reject_vld_r", 1'b0, reject_vld_r);
    check_bit("head_did_update_r", 1'b0, head_did_update_r);
    report_test(errs);
  endtask

  task automatic test_sorted_insert();
    entry_t      e;
    logic [31:0] rnd;
    price_t      tie_price;
    int          errs;
    cur_test = "sorted_insert";
    errs     = error_count;
    for (int n = 0; n < 6; n++) begin
      rnd = $random(seed);
      // Fifth order repeats the first price
      if (n == 4) begin
        new_entry(tie_price, e);
      end else begin
        new_entry({4'h1, rnd[11:0]}, e);
      end
      if (n == 0) begin
        tie_price = e.price;
      end
      insert_and_check(e);
    end
    report_test(errs);
  endtask

  task automatic test_pop_order();
    int errs;
    cur_test = "pop_order";
    errs     = error_count;
    check_bit("head_vld before pops", 1'b1, head_vld_r);
    while (model_q.size() > 0) begin
      pop_and_check();
    end
    report_test(errs);
  endtask

  task automatic test_overflow();
    entry_t      e;
    logic [31:0] rnd;
    int          errs;
    cur_test = "overflow";
    errs     = error_count;
    for (int n = 0; n < TABLE_DEPTH; n++) begin
      rnd = $random(seed);
      // Low nibble from the loop keeps fill prices distinct
      new_entry(16'h2000 + {4'h0, rnd[7:0], 4'h0} + price_t'(n), e);
      insert_and_check(e);
      check_bit("reject_vld while filling", 1'b0, reject_vld_r);
    end
    // Middle insert pushes the worst live order out
    new_entry(model_q[3].price + 16'd1, e);
    insert_and_check(e);
    check_bit("reject_vld after middle insert", 1'b1, reject_vld_r);
    check_entry("reject after middle insert", model_reject, reject_r);
    drive_reject_pop();
    check_bit("reject_vld after reject_pop", 1'b0, reject_vld_r);
    // Worse than the whole book, straight to reject
    new_entry(model_q[TABLE_DEPTH-1].price + 16'h0010, e);
    insert_and_check(e);
    check_bit("reject_vld after worst insert", 1'b1, reject_vld_r);
    check_entry("reject after worst insert", model_reject, reject_r);
    check_uid("rejected uid", e.uid, reject_r.uid);
    drive_reject_pop();
    check_bit("reject_vld after second reject_pop", 1'b0, reject_vld_r);
    report_test(errs);
  endtask

  task automatic test_cancel();
    entry_t target;
    entry_t ent;
    logic   hit;
    int     errs;
    cur_test = "cancel";
    errs     = error_count;
    target   = model_q[3];
    drive_cancel(target.uid, hit, ent);
    check_bit("cancel_hit", 1'b1, hit);
    check_entry("cancel_entry", target, ent);
    model_cancel(target.uid);
    // uid never handed out
    drive_cancel(8'hee, hit, ent);
    check_bit("cancel_hit on unknown uid", 1'b0, hit);
    while (model_q.size() > 0) begin
      pop_and_check();
    end
    report_test(errs);
  endtask

  initial begin
    rst          = 1'b1;
    insert       = 1'b0;
    insert_entry = EMPTY_ENTRY;
    cancel       = 1'b0;
    cancel_uid   = '0;
    head_pop     = 1'b0;
    reject_pop   = 1'b0;
    repeat (10) @(negedge clk);
    rst = 1'b0;

    test_reset();
    test_sorted_insert();
    test_pop_order();
    test_overflow();
    test_cancel();

    $display("Summary: %0d checks, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule
